// ==== dma_pkg.sv ====
package dma_pkg;

    // bus widths with a meaning
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [15:0] qty_t;
    typedef logic [7:0]  reg_off_t;

    // register map, byte offsets on the config bus
    localparam reg_off_t REG_SRC  = 8'h00;
    localparam reg_off_t REG_DST  = 8'h04;
    localparam reg_off_t REG_QTY  = 8'h08;
    localparam reg_off_t REG_CTRL = 8'h0C;
    localparam reg_off_t REG_STAT = 8'h10;

    // control and status bit positions
    localparam int CTRL_START_BIT = 0;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

    // engine word queue
    localparam int BUF_DEPTH = 4;
    localparam int BUF_PTR_W = 2;

    // one word per address step
    localparam int WORD_BYTES = 4;

    // engine FSM
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN
    } eng_state_t;

    // cpu config request, 42 bits
    typedef struct packed {
        logic     valid;
        logic     write;
        reg_off_t offset;
        data_t    wdata;
    } cfg_req_t;

    // config read data, 33 bits
    typedef struct packed {
        logic  valid;
        data_t rdata;
    } cfg_rsp_t;

    // read address channel
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } rd_req_t;

    // read data channel
    typedef struct packed {
        logic  valid;
        data_t data;
    } rd_rsp_t;

    // write channel, address and data in one beat
    typedef struct packed {
        logic  valid;
        addr_t addr;
        data_t data;
    } wr_req_t;

    // write response, no status
    typedef struct packed {
        logic valid;
    } wr_rsp_t;

endpackage

// ==== dma_reg_slave.sv ====
`timescale 1ns/1ps

module dma_reg_slave (
    input  logic              clk,
    input  logic              rst,
    input  dma_pkg::cfg_req_t cfg_req_i,
    output logic              cfg_ready_o,
    output dma_pkg::cfg_rsp_t cfg_rsp_o,
    input  logic              busy_i,
    input  logic              done_i,
    output logic              start_o,
    output dma_pkg::addr_t    src_o,
    output dma_pkg::addr_t    dst_o,
    output dma_pkg::qty_t     qty_o
);

    logic           start_wr;
    logic           accept;
    logic           wr_acc;
    logic           rd_acc;
    logic           rsp_valid;
    dma_pkg::data_t rsp_data;
    dma_pkg::data_t rdata_d;

    // control write that asks for a new transfer
    assign start_wr = cfg_req_i.valid && cfg_req_i.write &&
                      (cfg_req_i.offset == dma_pkg::REG_CTRL) &&
                      cfg_req_i.wdata[dma_pkg::CTRL_START_BIT];

    // hold off a start while the engine runs
    // start_o high also counts, busy only shows up a cycle later
    assign cfg_ready_o = !(start_wr && (busy_i || start_o));

    assign accept = cfg_req_i.valid && cfg_ready_o;
    assign wr_acc = accept && cfg_req_i.write;
    assign rd_acc = accept && !cfg_req_i.write;

    // setup registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_o <= '0;
            dst_o <= '0;
            qty_o <= '0;
        end else if (wr_acc) begin
            case (cfg_req_i.offset)
                dma_pkg::REG_SRC: src_o <= cfg_req_i.wdata;
                dma_pkg::REG_DST: dst_o <= cfg_req_i.wdata;
                // only the low half of the word is the count
                dma_pkg::REG_QTY: qty_o <= cfg_req_i.wdata[$bits(dma_pkg::qty_t)-1:0];
                default: ;
            endcase
        end
    end

    // one cycle start pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_o <= 1'b0;
        end else begin
            start_o <= start_wr && cfg_ready_o;
        end
    end

    // read mux
    always_comb begin
        rdata_d = '0;
        case (cfg_req_i.offset)
            dma_pkg::REG_SRC: rdata_d = src_o;
            dma_pkg::REG_DST: rdata_d = dst_o;
            dma_pkg::REG_QTY: rdata_d = dma_pkg::data_t'(qty_o);
            dma_pkg::REG_STAT: begin
                rdata_d[dma_pkg::STAT_BUSY_BIT] = busy_i;
                rdata_d[dma_pkg::STAT_DONE_BIT] = done_i;
            end
            // ctrl reads as zero, start self-clears
            default: rdata_d = '0;
        endcase
    end

    // response valid one cycle after an accepted read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rd_acc;
        end
    end

    // read data, only loaded on accepted reads
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rsp_data <= rdata_d;
        end
    end

    assign cfg_rsp_o = '{valid: rsp_valid, rdata: rsp_data};

    // engine never sees a start while busy
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (rst)
        start_o |-> !busy_i
    );

endmodule

// ==== dma_engine.sv ====
`timescale 1ns/1ps

module dma_engine (
    input  logic             clk,
    input  logic             rst,
    input  logic             start_i,
    input  dma_pkg::addr_t   src_i,
    input  dma_pkg::addr_t   dst_i,
    input  dma_pkg::qty_t    qty_i,
    output dma_pkg::rd_req_t rd_req_o,
    input  logic             rd_ready_i,
    input  dma_pkg::rd_rsp_t rd_rsp_i,
    output dma_pkg::wr_req_t wr_req_o,
    input  logic             wr_ready_i,
    input  dma_pkg::wr_rsp_t wr_rsp_i,
    output logic             busy_o,
    output logic             fin_o
);

    dma_pkg::eng_state_t state;

    // read side
    logic                     rd_valid;
    dma_pkg::addr_t           rd_addr;
    dma_pkg::qty_t            rd_left;
    // write side
    dma_pkg::addr_t           wr_addr;
    dma_pkg::qty_t            wr_left;
    dma_pkg::qty_t            rsp_left;
    // word queue
    dma_pkg::data_t           word_buf [dma_pkg::BUF_DEPTH];
    logic [dma_pkg::BUF_PTR_W-1:0] head;
    logic [dma_pkg::BUF_PTR_W-1:0] tail;
    logic [dma_pkg::BUF_PTR_W:0]   q_cnt;
    // queued words plus reads in flight
    logic [dma_pkg::BUF_PTR_W:0]   resv;

    logic launch;
    logic zero_go;
    logic rd_issue;
    logic rd_fire;
    logic push;
    logic wr_fire;
    logic last_rsp;

    assign launch  = (state == dma_pkg::IDLE) && start_i && (qty_i != '0);
    assign zero_go = (state == dma_pkg::IDLE) && start_i && (qty_i == '0);

    assign rd_fire = rd_valid && rd_ready_i;

    // next read only when the request slot frees and a queue slot is reserved
    assign rd_issue = launch ||
                      ((state == dma_pkg::RUN) && (!rd_valid || rd_ready_i) &&
                       (rd_left != '0) && (resv < (dma_pkg::BUF_PTR_W+1)'(dma_pkg::BUF_DEPTH)));

    // read data always taken, room was reserved at issue
    assign push = rd_rsp_i.valid;

    // write presented straight from the queue head
    assign wr_req_o = '{valid: (q_cnt != '0), addr: wr_addr, data: word_buf[head]};
    assign wr_fire  = wr_req_o.valid && wr_ready_i;

    assign rd_req_o = '{valid: rd_valid, addr: rd_addr};

    assign last_rsp = (state != dma_pkg::IDLE) && wr_rsp_i.valid && (rsp_left == 1);

    assign busy_o = (state != dma_pkg::IDLE);

    // FSM and counters
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= dma_pkg::IDLE;
            fin_o    <= 1'b0;
            rd_valid <= 1'b0;
            rd_left  <= '0;
            wr_left  <= '0;
            rsp_left <= '0;
        end else begin
            fin_o <= zero_go || last_rsp;

            // read request valid
            if (rd_issue) begin
                rd_valid <= 1'b1;
            end else if (rd_fire) begin
                rd_valid <= 1'b0;
            end

            if (launch) begin
                state    <= dma_pkg::RUN;
                rd_left  <= qty_i - 1'b1;
                wr_left  <= qty_i;
                rsp_left <= qty_i;
            end else begin
                if (rd_issue) begin
                    rd_left <= rd_left - 1'b1;
                end
                if (wr_fire) begin
                    wr_left <= wr_left - 1'b1;
                end
                if (wr_rsp_i.valid && (state != dma_pkg::IDLE)) begin
                    rsp_left <= rsp_left - 1'b1;
                end
                // all writes out, wait for responses
                if ((state == dma_pkg::RUN) && wr_fire && (wr_left == 1)) begin
                    state <= dma_pkg::DRAIN;
                end
                if (last_rsp) begin
                    state <= dma_pkg::IDLE;
                end
            end
        end
    end

    // queue pointers, occupancy and reservations
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            q_cnt <= '0;
            resv  <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (wr_fire) begin
                head <= head + 1'b1;
            end
            case ({push, wr_fire})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
            // slot freed only when its word leaves on the write channel
            case ({rd_issue, wr_fire})
                2'b10:   resv <= resv + 1'b1;
                2'b01:   resv <= resv - 1'b1;
                default: resv <= resv;
            endcase
        end
    end

    // addresses and queue storage
    always_ff @(posedge clk) begin
        if (launch) begin
            rd_addr <= src_i;
            wr_addr <= dst_i;
        end else begin
            if (rd_issue) begin
                rd_addr <= rd_addr + dma_pkg::addr_t'(dma_pkg::WORD_BYTES);
            end
            if (wr_fire) begin
                wr_addr <= wr_addr + dma_pkg::addr_t'(dma_pkg::WORD_BYTES);
            end
        end
        if (push) begin
            word_buf[tail] <= rd_rsp_i.data;
        end
    end

    // memory never returns more than was reserved
    a_q_overflow: assert property (
        @(posedge clk) disable iff (rst)
        rd_rsp_i.valid |-> (q_cnt < (dma_pkg::BUF_PTR_W+1)'(dma_pkg::BUF_DEPTH)) || wr_fire
    );

    // a wrap below zero shows up as an oversize count
    a_q_underflow: assert property (
        @(posedge clk) disable iff (rst)
        (q_cnt <= (dma_pkg::BUF_PTR_W+1)'(dma_pkg::BUF_DEPTH)) && (q_cnt <= resv)
    );

    a_rd_hold: assert property (
        @(posedge clk) disable iff (rst)
        rd_req_o.valid && !rd_ready_i |=> rd_req_o.valid && $stable(rd_req_o.addr)
    );

    a_wr_hold: assert property (
        @(posedge clk) disable iff (rst)
        wr_req_o.valid && !wr_ready_i |=>
            wr_req_o.valid && $stable(wr_req_o.addr) && $stable(wr_req_o.data)
    );

endmodule

// ==== dma_top.sv ====
`timescale 1ns/1ps

module dma_top (
    input  logic              clk,
    input  logic              rst,
    input  dma_pkg::cfg_req_t cfg_req_i,
    output logic              cfg_ready_o,
    output dma_pkg::cfg_rsp_t cfg_rsp_o,
    output dma_pkg::rd_req_t  rd_req_o,
    input  logic              rd_ready_i,
    input  dma_pkg::rd_rsp_t  rd_rsp_i,
    output dma_pkg::wr_req_t  wr_req_o,
    input  logic              wr_ready_i,
    input  dma_pkg::wr_rsp_t  wr_rsp_i,
    output logic              int_o
);

    // setup from the register slave
    dma_pkg::addr_t src;
    dma_pkg::addr_t dst;
    dma_pkg::qty_t  qty;
    logic           start;
    // engine status
    logic           busy;
    logic           fin;
    logic           fin_latch;

    // interrupt level, set on finish, cleared by the next start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fin_latch <= 1'b0;
        end else if (fin) begin
            fin_latch <= 1'b1;
        end else if (start) begin
            fin_latch <= 1'b0;
        end
    end

    // fin itself lifts int_o in the finish cycle
    assign int_o = fin | fin_latch;

    dma_reg_slave reg_s (
        .clk         (clk        ),
        .rst         (rst        ),
        .cfg_req_i   (cfg_req_i  ),
        .cfg_ready_o (cfg_ready_o),
        .cfg_rsp_o   (cfg_rsp_o  ),
        .busy_i      (busy       ),
        .done_i      (fin_latch  ),
        .start_o     (start      ),
        .src_o       (src        ),
        .dst_o       (dst        ),
        .qty_o       (qty        )
    );

    dma_engine engine (
        .clk        (clk       ),
        .rst        (rst       ),
        .start_i    (start     ),
        .src_i      (src       ),
        .dst_i      (dst       ),
        .qty_i      (qty       ),
        .rd_req_o   (rd_req_o  ),
        .rd_ready_i (rd_ready_i),
        .rd_rsp_i   (rd_rsp_i  ),
        .wr_req_o   (wr_req_o  ),
        .wr_ready_i (wr_ready_i),
        .wr_rsp_i   (wr_rsp_i  ),
        .busy_o     (busy      ),
        .fin_o      (fin       )
    );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model (
    input  logic             clk,
    input  logic             rst,
    input  int               wr_stall_pct_i,
    input  dma_pkg::rd_req_t rd_req_i,
    output logic             rd_ready_o,
    output dma_pkg::rd_rsp_t rd_rsp_o,
    input  dma_pkg::wr_req_t wr_req_i,
    output logic             wr_ready_o,
    output dma_pkg::wr_rsp_t wr_rsp_o
);

    localparam int MEM_WORDS    = 1024;
    localparam int RD_STALL_PCT = 25;
    // response latency 1 to MAX_LAT cycles
    localparam int MAX_LAT      = 4;
    localparam int TDRIVE       = 1;

    dma_pkg::data_t words [MEM_WORDS];
    int             seed;
    int             cyc;
    // pending read data and write responses, oldest first
    dma_pkg::data_t rd_data_q [$];
    int             rd_due_q [$];
    int             wr_due_q [$];
    // handshakes that complete on the coming edge
    logic             in_reset;
    logic             rd_fire;
    logic             wr_fire;
    dma_pkg::rd_req_t rd_hold;
    dma_pkg::wr_req_t wr_hold;

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'(r & 32'h7fff_ffff) % n;
    endfunction

    // word index from a byte address
    function automatic int word_index(input dma_pkg::addr_t addr);
        return int'(addr[11:2]);
    endfunction

    initial begin
        int i;
        seed = 32'h9a69_f17f;
        for (i = 0; i < MEM_WORDS; i++) begin
            words[i] = $random(seed);
        end
        rd_ready_o = 1'b0;
        wr_ready_o = 1'b0;
        rd_rsp_o   = '0;
        wr_rsp_o   = '0;
        cyc        = 0;
        forever begin
            // everything is settled mid cycle
            @(negedge clk);
            in_reset = rst;
            rd_fire  = rd_req_i.valid && rd_ready_o;
            wr_fire  = wr_req_i.valid && wr_ready_o;
            rd_hold  = rd_req_i;
            wr_hold  = wr_req_i;
            @(posedge clk);
            #TDRIVE;
            cyc++;
            rd_rsp_o = '0;
            wr_rsp_o = '0;
            if (in_reset) begin
                rd_ready_o = 1'b0;
                wr_ready_o = 1'b0;
                rd_data_q.delete();
                rd_due_q.delete();
                wr_due_q.delete();
            end else begin
                // read data taken at acceptance
                if (rd_fire) begin
                    rd_data_q.push_back(words[word_index(rd_hold.addr)]);
                    rd_due_q.push_back(cyc + 1 + rand_below(MAX_LAT));
                end
                if (wr_fire) begin
                    words[word_index(wr_hold.addr)] = wr_hold.data;
                    wr_due_q.push_back(cyc + 1 + rand_below(MAX_LAT));
                end
                // one beat per channel and cycle, in order
                if ((rd_due_q.size() > 0) && (rd_due_q[0] <= cyc)) begin
                    rd_rsp_o.valid = 1'b1;
                    rd_rsp_o.data  = rd_data_q.pop_front();
                    void'(rd_due_q.pop_front());
                end
                if ((wr_due_q.size() > 0) && (wr_due_q[0] <= cyc)) begin
                    wr_rsp_o.valid = 1'b1;
                    void'(wr_due_q.pop_front());
                end
                rd_ready_o = (rand_below(100) >= RD_STALL_PCT);
                wr_ready_o = (rand_below(100) >= wr_stall_pct_i);
            end
        end
    end

endmodule

// ==== tb_dma_top.sv ====
`timescale 1ns/1ps

module tb_dma_top;

    localparam int MEM_WORDS = 1024;
    localparam int NUM_XFERS = 12;
    localparam int MAX_QTY   = 40;
    localparam int TDRIVE    = 1;
    // 13 transfers of up to 40 words, a few cycles per word at 75% write stall
    localparam int TIMEOUT_CYCLES = 20000;

    logic              clk;
    logic              rst;
    dma_pkg::cfg_req_t cfg_req;
    logic              cfg_ready;
    dma_pkg::cfg_rsp_t cfg_rsp;
    dma_pkg::rd_req_t  rd_req;
    logic              rd_ready;
    dma_pkg::rd_rsp_t  rd_rsp;
    dma_pkg::wr_req_t  wr_req;
    logic              wr_ready;
    dma_pkg::wr_rsp_t  wr_rsp;
    logic              irq;
    int                wr_stall_pct;

    int             seed;
    int             cycles = 0;
    // reference model of the running transfer
    dma_pkg::data_t before_img [MEM_WORDS];
    dma_pkg::data_t shadow [MAX_QTY];
    int             src_base = 0;
    int             dst_base = 0;
    int             xfer_qty = 0;
    int             rd_seen  = 0;
    int             wr_seen  = 0;
    int             rsp_seen = 0;
    logic           int_pending;

    dma_top uut (
        .clk         (clk      ),
        .rst         (rst      ),
        .cfg_req_i   (cfg_req  ),
        .cfg_ready_o (cfg_ready),
        .cfg_rsp_o   (cfg_rsp  ),
        .rd_req_o    (rd_req   ),
        .rd_ready_i  (rd_ready ),
        .rd_rsp_i    (rd_rsp   ),
        .wr_req_o    (wr_req   ),
        .wr_ready_i  (wr_ready ),
        .wr_rsp_i    (wr_rsp   ),
        .int_o       (irq      )
    );

    tb_mem_model mem (
        .clk            (clk         ),
        .rst            (rst         ),
        .wr_stall_pct_i (wr_stall_pct),
        .rd_req_i       (rd_req      ),
        .rd_ready_o     (rd_ready    ),
        .rd_rsp_o       (rd_rsp      ),
        .wr_req_i       (wr_req      ),
        .wr_ready_o     (wr_ready    ),
        .wr_rsp_o       (wr_rsp      )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: transfers did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic fail_stop(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'(r & 32'h7fff_ffff) % n;
    endfunction

    // slave takes these at once, return just after the accepting edge
    task automatic cfg_send(input dma_pkg::cfg_req_t req);
        cfg_req = req;
        @(negedge clk);
        assert (cfg_ready) else fail_stop("config request was not taken at once");
        @(posedge clk);
        #TDRIVE;
        cfg_req = '0;
    endtask

    task automatic cfg_write(input dma_pkg::reg_off_t off, input dma_pkg::data_t data);
        dma_pkg::cfg_req_t req;
        req = '{valid: 1'b1, write: 1'b1, offset: off, wdata: data};
        cfg_send(req);
    endtask

    // response lands in the cycle after acceptance
    task automatic cfg_read(input dma_pkg::reg_off_t off, output dma_pkg::data_t data);
        dma_pkg::cfg_req_t req;
        req = '{valid: 1'b1, write: 1'b0, offset: off, wdata: '0};
        cfg_send(req);
        @(negedge clk);
        assert (cfg_rsp.valid) else fail_stop("no read response one cycle after the read");
        data = cfg_rsp.rdata;
        @(posedge clk);
        #TDRIVE;
    endtask

    // start offered for one cycle while the engine runs, then withdrawn
    task automatic check_start_held_off();
        cfg_req = '{valid: 1'b1, write: 1'b1, offset: dma_pkg::REG_CTRL,
                    wdata: dma_pkg::data_t'(1) << dma_pkg::CTRL_START_BIT};
        @(negedge clk);
        assert (!cfg_ready) else fail_stop("start write was taken while the engine was busy");
        @(posedge clk);
        #TDRIVE;
        cfg_req = '0;
    endtask

    task automatic write_read_back(input dma_pkg::reg_off_t off, input dma_pkg::data_t value);
        dma_pkg::data_t rdata;
        cfg_write(off, value);
        cfg_read(off, rdata);
        assert (rdata == value)
        else fail_stop($sformatf("reg %h read %h expected %h", off, rdata, value));
    endtask

    // bus monitor, mid cycle so every handshake is settled
    always @(negedge clk) begin
        if (!rst) begin
            // nothing on the bus while no words are due
            assert ((xfer_qty != 0) || !(rd_req.valid || wr_req.valid))
            else fail_stop("bus request during a zero word transfer");
            if (rd_req.valid && rd_ready) begin
                assert (rd_req.addr == dma_pkg::addr_t'(src_base + dma_pkg::WORD_BYTES * rd_seen))
                else fail_stop($sformatf("read %0d at address %h", rd_seen, rd_req.addr));
                rd_seen++;
            end
            if (wr_req.valid && wr_ready) begin
                assert (wr_seen < xfer_qty)
                else fail_stop($sformatf("extra write at address %h", wr_req.addr));
                assert (wr_req.addr == dma_pkg::addr_t'(dst_base + dma_pkg::WORD_BYTES * wr_seen))
                else fail_stop($sformatf("write %0d at address %h", wr_seen, wr_req.addr));
                assert (wr_req.data == shadow[wr_seen])
                else fail_stop($sformatf("write %0d data %h expected %h",
                                         wr_seen, wr_req.data, shadow[wr_seen]));
                wr_seen++;
            end
            if (wr_rsp.valid) begin
                rsp_seen++;
            end
            // queue bound, reads never run ahead of writes by more than its depth
            assert (rd_seen <= wr_seen + dma_pkg::BUF_DEPTH)
            else fail_stop($sformatf("%0d reads against %0d writes", rd_seen, wr_seen));
        end
    end

    // whole memory against shadow copy and pre-transfer image
    task automatic check_memory(input int dst_w, input int qty);
        int             i;
        dma_pkg::data_t expected;
        for (i = 0; i < MEM_WORDS; i++) begin
            if ((i >= dst_w) && (i < dst_w + qty)) begin
                expected = shadow[i - dst_w];
            end else begin
                expected = before_img[i];
            end
            assert (mem.words[i] == expected)
            else fail_stop($sformatf("mem word %0d is %h expected %h", i, mem.words[i], expected));
        end
    endtask

    task automatic run_transfer(input int src_w, input int dst_w, input int qty, input int stall);
        int             i;
        dma_pkg::data_t rdata;
        wr_stall_pct = stall;
        for (i = 0; i < MEM_WORDS; i++) begin
            before_img[i] = mem.words[i];
        end
        for (i = 0; i < qty; i++) begin
            shadow[i] = mem.words[src_w + i];
        end
        src_base = src_w * dma_pkg::WORD_BYTES;
        dst_base = dst_w * dma_pkg::WORD_BYTES;
        xfer_qty = qty;
        rd_seen  = 0;
        wr_seen  = 0;
        rsp_seen = 0;
        cfg_write(dma_pkg::REG_SRC, dma_pkg::data_t'(src_base));
        cfg_write(dma_pkg::REG_DST, dma_pkg::data_t'(dst_base));
        cfg_write(dma_pkg::REG_QTY, dma_pkg::data_t'(qty));
        // level from the previous transfer still up
        @(negedge clk);
        assert (irq == int_pending) else fail_stop("interrupt level wrong before start");
        @(posedge clk);
        #TDRIVE;
        cfg_write(dma_pkg::REG_CTRL, dma_pkg::data_t'(1) << dma_pkg::CTRL_START_BIT);
        if (qty > 0) begin
            // start pulse now, latch cleared on the next edge
            @(posedge clk);
            #TDRIVE;
            @(negedge clk);
            assert (!irq) else fail_stop("interrupt still high after start");
            @(posedge clk);
            #TDRIVE;
            cfg_read(dma_pkg::REG_STAT, rdata);
            assert (rdata[dma_pkg::STAT_BUSY_BIT] && !rdata[dma_pkg::STAT_DONE_BIT])
            else fail_stop($sformatf("status %h during transfer", rdata));
            // earliest finish is still a few cycles away
            check_start_held_off();
        end
        @(negedge clk);
        while (!irq) @(negedge clk);
        assert (rsp_seen == qty)
        else fail_stop($sformatf("interrupt after %0d of %0d responses", rsp_seen, qty));
        @(posedge clk);
        #TDRIVE;
        cfg_read(dma_pkg::REG_STAT, rdata);
        assert (!rdata[dma_pkg::STAT_BUSY_BIT] && rdata[dma_pkg::STAT_DONE_BIT])
        else fail_stop($sformatf("status %h after finish", rdata));
        @(negedge clk);
        assert (irq) else fail_stop("interrupt dropped before the next start");
        assert ((rd_seen == qty) && (wr_seen == qty))
        else fail_stop($sformatf("%0d reads %0d writes for %0d words", rd_seen, wr_seen, qty));
        check_memory(dst_w, qty);
        @(posedge clk);
        #TDRIVE;
        int_pending = 1'b1;
    endtask

    initial begin
        dma_pkg::data_t rdata;
        int             t;
        int             qty;
        int             src_w;
        int             dst_w;
        seed         = 32'h9a69_f17f;
        rst          = 1'b1;
        cfg_req      = '0;
        wr_stall_pct = 20;
        int_pending  = 1'b0;
        repeat (5) @(posedge clk);
        #TDRIVE;
        rst = 1'b0;

        // idle status and register read-back
        cfg_read(dma_pkg::REG_STAT, rdata);
        assert (rdata[dma_pkg::STAT_DONE_BIT:dma_pkg::STAT_BUSY_BIT] == 2'b00)
        else fail_stop($sformatf("status %h after reset", rdata));
        write_read_back(dma_pkg::REG_SRC, dma_pkg::data_t'($random(seed)));
        write_read_back(dma_pkg::REG_DST, dma_pkg::data_t'($random(seed)));
        write_read_back(dma_pkg::REG_QTY, dma_pkg::data_t'($random(seed)) & 32'h0000_ffff);

        // zero count, interrupt only
        run_transfer(16, 512, 0, 20);

        // random copies, last few under heavy write stall
        for (t = 0; t < NUM_XFERS; t++) begin
            qty   = 1 + rand_below(MAX_QTY);
            src_w = rand_below(MEM_WORDS - qty + 1);
            dst_w = rand_below(MEM_WORDS - qty + 1);
            while ((dst_w < src_w + qty) && (src_w < dst_w + qty)) begin
                dst_w = rand_below(MEM_WORDS - qty + 1);
            end
            run_transfer(src_w, dst_w, qty, (t >= 8) ? 75 : 20);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== dma_top.f ====
dma_pkg.sv
dma_reg_slave.sv
dma_engine.sv
dma_top.sv
tb_mem_model.sv
tb_dma_top.sv

// ==== run.sh ====
#!/bin/bash
# build and run the DMA testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_dma_top \
    -f dma_top.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_dma_top > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
